// File: hdl/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // buffer geometry
    //////////////////////////////////////////////////
    localparam int line_bytes = 16;
    localparam int num_lines  = 4;
    localparam int buf_bytes  = line_bytes * num_lines;

    // byte k of a line sits at bits 8k+7 to 8k
    typedef logic [8*line_bytes-1:0] line_t;
    typedef logic [1:0]              slot_t;
    typedef logic [3:0]              length_t;

    //////////////////////////////////////////////////
    // fetch pointer
    //////////////////////////////////////////////////
    typedef struct packed {
        slot_t      line;
        logic [3:0] offset;
    } fetch_pos_t;

    // flat byte address or line/offset pair
    typedef union packed {
        logic [5:0] addr;
        fetch_pos_t pos;
    } fetch_ptr_u;

    //////////////////////////////////////////////////
    // bundles between blocks
    //////////////////////////////////////////////////
    typedef struct packed {
        logic       is_init;
        logic       is_resteer;
        logic       is_br;
        fetch_ptr_u init_target;
        fetch_ptr_u wb_target;
        fetch_ptr_u bp_target;
    } cf_req_t;

    typedef struct packed {
        logic  valid;
        slot_t slot;
        line_t data;
    } fill_wr_t;

    typedef struct packed {
        logic  valid;
        slot_t slot;
    } release_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } packet_t;

endpackage

// File: hdl/ibuf_line.sv
`timescale 1ns/1ps

module ibuf_line #(
    parameter fetch_pkg::slot_t slot_id = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  fetch_pkg::fill_wr_t fill_wr,
    input  fetch_pkg::release_t rel,
    input  logic               flush,
    output fetch_pkg::line_t    line,
    output logic               valid
);

    logic fill_hit;
    logic rel_hit;

    assign fill_hit = fill_wr.valid && (fill_wr.slot == slot_id);
    assign rel_hit  = rel.valid && (rel.slot == slot_id);

    // line payload
    always_ff @(posedge clk) begin
        if (fill_hit) begin
            line <= fill_wr.data;
        end
    end

    // flush beats fill, fill beats release
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (fill_hit) begin
            valid <= 1'b1;
        end else if (rel_hit) begin
            valid <= 1'b0;
        end
    end

endmodule

// File: hdl/ibuf_fill.sv
`timescale 1ns/1ps

module ibuf_fill (
    input  logic                              clk,
    input  logic                              reset,
    input  fetch_pkg::line_t                  line_in,
    input  logic                              line_in_valid,
    input  logic [fetch_pkg::num_lines-1:0]   slot_valid,
    input  logic                              flush,
    input  fetch_pkg::slot_t                  flush_line,
    output fetch_pkg::fill_wr_t               fill_wr,
    output logic                              fill_ready
);

    fetch_pkg::slot_t wr_ptr;
    logic             accept;

    //////////////////////////////////////////////////
    // back-pressure and accept
    //////////////////////////////////////////////////

    // next slot to fill must be free
    assign fill_ready = ~slot_valid[wr_ptr];

    // strobes during a flush are dropped
    assign accept = line_in_valid && fill_ready && !flush;

    //////////////////////////////////////////////////
    // slot write
    //////////////////////////////////////////////////
    always_comb begin
        fill_wr.valid = accept;
        fill_wr.slot  = wr_ptr;
        fill_wr.data  = line_in;
    end

    //////////////////////////////////////////////////
    // write pointer
    //////////////////////////////////////////////////

    // restart at the redirect target's line
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= flush_line;
        end else if (accept) begin
            // wraps mod 4
            wr_ptr <= wr_ptr + 2'd1;
        end
    end

endmodule

// File: hdl/fetch_align.sv
`timescale 1ns/1ps

module fetch_align (
    input  logic                                        clk,
    input  logic                                        reset,
    input  fetch_pkg::line_t [fetch_pkg::num_lines-1:0] lines,
    input  logic [fetch_pkg::num_lines-1:0]             slot_valid,
    input  fetch_pkg::length_t                          length,
    input  logic                                        stall,
    input  fetch_pkg::cf_req_t                          cf,
    output fetch_pkg::packet_t                          packet,
    output fetch_pkg::release_t                         rel,
    output logic                                        flush,
    output fetch_pkg::slot_t                            flush_line
);

    localparam int buf_bits = 8 * fetch_pkg::buf_bytes;

    fetch_pkg::fetch_ptr_u ptr;
    fetch_pkg::fetch_ptr_u cf_target;
    fetch_pkg::fetch_ptr_u seq_ptr;
    fetch_pkg::fetch_ptr_u start;
    fetch_pkg::slot_t      next_line;
    logic                  cf_req;
    logic                  seq_ld;
    logic                  ptr_ld;
    logic [buf_bits-1:0]   rot;

    //////////////////////////////////////////////////
    // control-flow select
    //////////////////////////////////////////////////
    assign cf_req = cf.is_init || cf.is_resteer || cf.is_br;

    // init over resteer over branch
    always_comb begin
        if (cf.is_init) begin
            cf_target = cf.init_target;
        end else if (cf.is_resteer) begin
            cf_target = cf.wb_target;
        end else begin
            cf_target = cf.bp_target;
        end
    end

    //////////////////////////////////////////////////
    // next pointer
    //////////////////////////////////////////////////

    // wraps at 64 bytes
    assign seq_ptr.addr = ptr.addr + {2'b00, length};
    assign start        = cf_req ? cf_target : seq_ptr;
    assign next_line    = start.pos.line + 2'd1;

    // start line and its successor must both be present
    assign packet.valid = slot_valid[start.pos.line] && slot_valid[next_line];

    //////////////////////////////////////////////////
    // byte rotator
    //////////////////////////////////////////////////

    // each log stage rotates by 2^s bytes
    always_comb begin
        rot = lines;
        for (int s = 0; s < 6; s++) begin
            if (start.addr[s]) begin
                rot = (rot >> (8 << s)) | (rot << (buf_bits - (8 << s)));
            end
        end
    end

    assign packet.data = rot[8*fetch_pkg::line_bytes-1:0];

    //////////////////////////////////////////////////
    // pointer register and slot control
    //////////////////////////////////////////////////
    assign seq_ld = !cf_req && !stall && packet.valid;
    assign ptr_ld = cf_req || seq_ld;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (ptr_ld) begin
            ptr <= start;
        end
    end

    // a redirect empties the buffer
    assign flush      = cf_req;
    assign flush_line = cf_target.pos.line;

    // old line is done once the pointer leaves it
    always_comb begin
        rel.valid = seq_ld && (start.pos.line != ptr.pos.line);
        rel.slot  = ptr.pos.line;
    end

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::line_t     line_in,
    input  logic                 line_in_valid,
    input  fetch_pkg::length_t   length,
    input  logic                 stall,
    input  fetch_pkg::cf_req_t   cf,
    output logic                 fill_ready,
    output fetch_pkg::packet_t   packet
);

    fetch_pkg::fill_wr_t                         fill_wr;
    fetch_pkg::release_t                         rel;
    logic                                        flush;
    fetch_pkg::slot_t                            flush_line;
    fetch_pkg::line_t [fetch_pkg::num_lines-1:0] slot_lines;
    logic [fetch_pkg::num_lines-1:0]             slot_valid;

    //////////////////////////////////////////////////
    // line filler
    //////////////////////////////////////////////////
    ibuf_fill u_fill (
        .clk           (clk),
        .reset         (reset),
        .line_in       (line_in),
        .line_in_valid (line_in_valid),
        .slot_valid    (slot_valid),
        .flush         (flush),
        .flush_line    (flush_line),
        .fill_wr       (fill_wr),
        .fill_ready    (fill_ready)
    );

    //////////////////////////////////////////////////
    // buffer slots
    //////////////////////////////////////////////////
    for (genvar i = 0; i < fetch_pkg::num_lines; i++) begin : g_slot
        ibuf_line #(
            .slot_id (fetch_pkg::slot_t'(i))
        ) u_line (
            .clk     (clk),
            .reset   (reset),
            .fill_wr (fill_wr),
            .rel     (rel),
            .flush   (flush),
            .line    (slot_lines[i]),
            .valid   (slot_valid[i])
        );
    end

    //////////////////////////////////////////////////
    // aligner
    //////////////////////////////////////////////////
    fetch_align u_align (
        .clk        (clk),
        .reset      (reset),
        .lines      (slot_lines),
        .slot_valid (slot_valid),
        .length     (length),
        .stall      (stall),
        .cf         (cf),
        .packet     (packet),
        .rel        (rel),
        .flush      (flush),
        .flush_line (flush_line)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 100 ns period
    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
    end

    always begin
        #half_period clk = ~clk;
    end

endmodule

// File: tb/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    typedef struct packed {
        logic       fill;
        logic [3:0] len;
        logic       stall;
        logic [2:0] cf;
        logic [5:0] init_tgt;
        logic [5:0] wb_tgt;
        logic [5:0] bp_tgt;
        logic [7:0] test;
        logic       exp_valid;
    } record_t;

    logic               clk;
    logic               reset;
    fetch_pkg::line_t   line_in;
    logic               line_in_valid;
    fetch_pkg::length_t length;
    logic               stall;
    fetch_pkg::cf_req_t cf;
    logic               fill_ready;
    fetch_pkg::packet_t packet;

    record_t    recs[$];
    logic [7:0] m_buf [64];
    logic [3:0] m_valid;
    logic [5:0] m_ptr;
    logic [1:0] m_wr;
    int         err_count;
    int         test_errs;
    int         tests_run;
    int         tests_failed;
    int         cycles;
    int         limit;
    int         cur_test;

    tb_clock u_clk (.clk(clk));

    fetch_top uut (
        .clk           (clk),
        .reset         (reset),
        .line_in       (line_in),
        .line_in_valid (line_in_valid),
        .length        (length),
        .stall         (stall),
        .cf            (cf),
        .fill_ready    (fill_ready),
        .packet        (packet)
    );

    //////////////////////////////////////////////////
    // stimulus file and helpers
    //////////////////////////////////////////////////
    task automatic read_records();
        int      fd;
        int      n;
        int      v [8];
        string   txt;
        string   op;
        record_t r;
        fd = $fopen("tb/fetch_input.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(txt, fd) != 0) begin
            if (txt.len() > 1 && txt[0] != "#") begin
                n = $sscanf(txt, "%s %h %h %h %h %h %h %d %d", op,
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                if (n == 9) begin
                    r.fill      = (op == "fill");
                    r.len       = v[0];
                    r.stall     = v[1];
                    r.cf        = v[2];
                    r.init_tgt  = v[3];
                    r.wb_tgt    = v[4];
                    r.bp_tgt    = v[5];
                    r.test      = v[6];
                    r.exp_valid = v[7];
                    recs.push_back(r);
                end else begin
                    $display("malformed stimulus record skipped: %s", txt);
                    err_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    function automatic fetch_pkg::line_t random_line();
        fetch_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[32*w +: 32] = $urandom();
        end
        return l;
    endfunction

    task automatic note_error(input string msg);
        err_count++;
        test_errs++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic close_test(input int num);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d passed", num);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", num, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic apply_record(input record_t r);
        line_in_valid = r.fill;
        if (r.fill) begin
            line_in = random_line();
        end
        length                = r.len;
        stall                 = r.stall;
        cf.is_init            = r.cf[2];
        cf.is_resteer         = r.cf[1];
        cf.is_br              = r.cf[0];
        cf.init_target.addr   = r.init_tgt;
        cf.wb_target.addr     = r.wb_tgt;
        cf.bp_target.addr     = r.bp_tgt;
    endtask

    //////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////
    task automatic check_record(input record_t r, input int idx);
        logic             req;
        logic             accept;
        logic             exp_valid;
        logic             exp_ready;
        logic [5:0]       tgt;
        logic [5:0]       start;
        logic [1:0]       sl;
        logic [1:0]       nl;
        fetch_pkg::line_t exp_data;
        req       = |r.cf;
        tgt       = r.cf[2] ? r.init_tgt : (r.cf[1] ? r.wb_tgt : r.bp_tgt);
        start     = req ? tgt : m_ptr + 6'(r.len);
        sl        = start[5:4];
        nl        = sl + 2'd1;
        exp_valid = m_valid[sl] && m_valid[nl];
        exp_ready = !m_valid[m_wr];
        for (int k = 0; k < 16; k++) begin
            exp_data[8*k +: 8] = m_buf[(start + k) % 64];
        end
        if (packet.valid !== exp_valid) begin
            note_error($sformatf("record %0d packet valid %b, expected %b",
                                 idx, packet.valid, exp_valid));
        end
        if (exp_valid !== r.exp_valid) begin
            note_error($sformatf("record %0d lists valid %b, model gives %b",
                                 idx, r.exp_valid, exp_valid));
        end
        if (exp_valid && packet.data !== exp_data) begin
            note_error($sformatf("record %0d packet %h, expected %h",
                                 idx, packet.data, exp_data));
        end
        if (fill_ready !== exp_ready) begin
            note_error($sformatf("record %0d fill_ready %b, expected %b",
                                 idx, fill_ready, exp_ready));
        end
        // state after the coming edge
        accept = r.fill && exp_ready && !req;
        if (req) begin
            m_valid = '0;
            m_wr    = tgt[5:4];
            m_ptr   = tgt;
        end else begin
            if (!r.stall && exp_valid) begin
                if (sl != m_ptr[5:4]) begin
                    m_valid[m_ptr[5:4]] = 1'b0;
                end
                m_ptr = start;
            end
            // a fill lands after any release of the same slot
            if (accept) begin
                for (int k = 0; k < 16; k++) begin
                    m_buf[m_wr*16 + k] = line_in[8*k +: 8];
                end
                m_valid[m_wr] = 1'b1;
                m_wr          = m_wr + 2'd1;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("run stopped after reaching the limit of %0d cycles", limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h1c2a7b98));
        reset         = 1'b1;
        line_in       = '0;
        line_in_valid = 1'b0;
        length        = '0;
        stall         = 1'b1;
        cf            = '0;
        m_valid       = '0;
        m_ptr         = '0;
        m_wr          = '0;
        err_count     = 0;
        test_errs     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        cycles        = 0;
        limit         = 0;
        read_records();
        limit = 16 + 4 * recs.size();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        if (recs.size() == 0) begin
            $display("no stimulus records could be read from tb/fetch_input.txt");
            err_count++;
        end else begin
            cur_test = recs[0].test;
            foreach (recs[i]) begin
                if (recs[i].test != cur_test) begin
                    close_test(cur_test);
                    cur_test = recs[i].test;
                end
                @(negedge clk);
                apply_record(recs[i]);
                #20;
                check_record(recs[i], i);
            end
            close_test(cur_test);
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb/fetch_input.txt
# op len stall cf(init,resteer,br bits) init_tgt wb_tgt bp_tgt test exp_valid
# len, cf and targets in hex; fill strobes a new random line
fill     0 1 0 00 00 00 1 0
fill     0 1 0 00 00 00 1 0
idle     0 1 0 00 00 00 1 1
fill     0 1 0 00 00 00 1 1
fill     0 1 0 00 00 00 1 1
step     0 0 0 00 00 00 2 1
step     1 0 0 00 00 00 2 1
step     2 0 0 00 00 00 2 1
step     3 0 0 00 00 00 2 1
step     4 0 0 00 00 00 2 1
step     5 0 0 00 00 00 2 1
step     6 0 0 00 00 00 2 1
fill     7 0 0 00 00 00 2 1
step     8 0 0 00 00 00 2 1
fill     9 0 0 00 00 00 2 1
step     a 0 0 00 00 00 2 1
fill     b 0 0 00 00 00 2 1
fill     c 0 0 00 00 00 2 1
step     d 0 0 00 00 00 2 1
step     e 0 0 00 00 00 2 1
step     f 0 0 00 00 00 2 0
fill     f 0 0 00 00 00 2 0
step     f 0 0 00 00 00 2 1
fill     0 1 0 00 00 00 2 1
fill     0 1 0 00 00 00 2 1
step     5 1 0 00 00 00 3 1
step     5 1 0 00 00 00 3 1
step     5 0 0 00 00 00 3 1
step     5 0 0 00 00 00 3 1
fill     0 1 0 00 00 00 4 1
fill     0 1 0 00 00 00 4 1
idle     0 1 0 00 00 00 4 1
step     e 0 0 00 00 00 4 1
fill     0 1 0 00 00 00 4 1
step     f 0 0 00 00 00 4 1
step     f 0 0 00 00 00 4 1
step     f 0 0 00 00 00 4 1
redirect 0 1 7 0e 25 33 5 0
fill     0 1 0 00 00 00 5 0
fill     0 1 0 00 00 00 5 0
idle     0 1 0 00 00 00 5 1
step     3 0 0 00 00 00 5 0
redirect 0 1 3 00 25 08 6 0
idle     0 1 0 00 00 00 6 0
fill     0 1 0 00 00 00 6 0
fill     0 1 0 00 00 00 6 0
step     2 0 0 00 00 00 6 1
step     9 0 0 00 00 00 6 0
fill     9 0 0 00 00 00 6 0
step     9 0 0 00 00 00 6 1

// File: project.f
hdl/fetch_pkg.sv
hdl/ibuf_line.sv
hdl/ibuf_fill.sv
hdl/fetch_align.sv
hdl/fetch_top.sv
tb/tb_clock.sv
tb/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_align

sources:
  - hdl/fetch_pkg.sv
  - hdl/ibuf_line.sv
  - hdl/ibuf_fill.sv
  - hdl/fetch_align.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/fetch_tb.sv
